// File: Bender.yml
package:
  name: triBridge

sources:
  # design, package first
  - rtl/triBridgePkg.sv
  - rtl/cacheReqIf.sv
  - rtl/reqArbiter.sv
  - rtl/respRouter.sv
  - rtl/triBridge.sv

  # testbench, top is triBridgeTb
  - target: simulation
    files:
      - sim/triBridgeChecker.sv
      - sim/triBridgeTb.sv

# the same order as triBridge.f
# rtl top level is triBridge

// File: rtl/cacheReqIf.sv
`timescale 1ns/1ns
`default_nettype none

// one granted core request on its way to the arbiter
interface cacheReqIf
  import triBridgePkg::*;
();

  // which cache source won
  reqKind_t kind;
  // full physical address, offset zero for fills
  paddr_t addr;
  // store data, zero otherwise
  word_t data;
  sizeCode_t size;
  logic valid;
  // high only while the arbiter is idle
  logic ready;

  // driven from the priority select in the top
  modport source (
    output kind, addr, data, size, valid,
    input  ready
  );

  // consumed by the request arbiter
  modport sink (
    input  kind, addr, data, size, valid,
    output ready
  );

endinterface

`default_nettype wire

// File: rtl/reqArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module reqArbiter
  import triBridgePkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  cacheReqIf.sink   req,
  input  logic      triHeaderAck_i,
  output logic      triReqVal_o,
  output reqType_t  triReqType_o,
  output sizeCode_t triReqSize_o,
  output paddr_t    triReqAddr_o,
  output word_t     triReqData_o
);

  arbState_t state;
  arbState_t stateNext;
  logic accept;

  // request kind to memory request type
  function automatic reqType_t kindToType(input reqKind_t kind);
    reqType_t code;
    case (kind)
      KIND_STORE: code = RQ_STORE;
      KIND_LOAD: code = RQ_LOAD;
      default: code = RQ_IMISS;
    endcase
    return code;
  endfunction

  // only take a new request when nothing is outstanding
  assign req.ready = (state == ARB_IDLE);
  assign accept = req.valid && req.ready;

  // valid follows the wait state, so it rises the cycle after accept
  assign triReqVal_o = (state == ARB_WAIT_HDR);

  always_comb begin
    stateNext = state;
    case (state)
      ARB_IDLE: begin
        if (accept) begin
          stateNext = ARB_WAIT_HDR;
        end
      end
      ARB_WAIT_HDR: begin
        // header taken, free for the next grant
        if (triHeaderAck_i) begin
          stateNext = ARB_IDLE;
        end
      end
      default: stateNext = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ARB_IDLE;
    end else begin
      state <= stateNext;
    end
  end

  // request fields captured on accept, held until the header ack
  always_ff @(posedge clk) begin
    if (accept) begin
      triReqType_o <= kindToType(req.kind);
      triReqSize_o <= req.size;
      triReqAddr_o <= req.addr;
      triReqData_o <= req.data;
    end
  end

  // a request still waiting for its header ack keeps valid and every field
  property pHoldUntilAck;
    @(posedge clk) disable iff (!rst_n)
      triReqVal_o && !triHeaderAck_i |=>
        triReqVal_o && $stable(triReqType_o) && $stable(triReqSize_o) &&
        $stable(triReqAddr_o) && $stable(triReqData_o);
  endproperty

  aHoldUntilAck: assert property (pHoldUntilAck)
    else $error("memory request changed or dropped before header ack");

endmodule

`default_nettype wire

// File: rtl/respRouter.sv
`timescale 1ns/1ns
`default_nettype none

module respRouter
  import triBridgePkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      triRespVal_i,
  input  retType_t  triRespType_i,
  input  paddr_t    triRespAddr_i,
  input  word_t     triRespData0_i,
  input  word_t     triRespData1_i,
  input  word_t     triRespData2_i,
  input  word_t     triRespData3_i,
  input  logic      triRespInvalIc_i,
  input  logic      triRespInvalDc_i,
  output logic      triRespAck_o,
  output logic      icFillValid_o,
  output cacheTag_t icFillTag_o,
  output icIndex_t  icFillIndex_o,
  output icLine_t   icFillData_o,
  output logic      dcFillValid_o,
  output cacheTag_t dcFillTag_o,
  output dcIndex_t  dcFillIndex_o,
  output dcLine_t   dcFillData_o,
  output logic      stComplete_o,
  output logic      icInvValid_o,
  output icIndex_t  icInvIndex_o,
  output logic      dcInvValid_o,
  output dcIndex_t  dcInvIndex_o,
  output logic      coreReset_o
);

  cacheTag_t respTag;
  icIndex_t respIcIndex;
  dcIndex_t respDcIndex;
  logic isIfill;
  logic isLoad;
  logic isStack;
  logic isEvict;
  logic isInt;
  logic wakeFlag;

  // fills are never refused
  assign triRespAck_o = triRespVal_i;

  // address split by cache geometry
  // the tag bits line up for both caches
  assign respTag = triRespAddr_i[PADDR_W-1 -: TAG_W];
  assign respIcIndex = triRespAddr_i[IC_OFFSET_W +: IC_INDEX_W];
  assign respDcIndex = triRespAddr_i[DC_OFFSET_W +: DC_INDEX_W];

  // return type decode that drops any other code
  assign isIfill = triRespVal_i && (triRespType_i == RET_IFILL);
  assign isLoad = triRespVal_i && (triRespType_i == RET_LOAD);
  assign isStack = triRespVal_i && (triRespType_i == RET_STACK);
  assign isEvict = triRespVal_i && (triRespType_i == RET_EVICT);
  assign isInt = triRespVal_i && (triRespType_i == RET_INT);

  // one-cycle pulses one clock behind the response
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      icFillValid_o <= 1'b0;
      dcFillValid_o <= 1'b0;
      stComplete_o <= 1'b0;
      icInvValid_o <= 1'b0;
      dcInvValid_o <= 1'b0;
      wakeFlag <= 1'b0;
    end else begin
      icFillValid_o <= isIfill;
      dcFillValid_o <= isLoad;
      stComplete_o <= isStack;
      icInvValid_o <= isEvict && triRespInvalIc_i;
      dcInvValid_o <= isEvict && triRespInvalDc_i;
      // sticky until the next reset
      if (isInt) begin
        wakeFlag <= 1'b1;
      end
    end
  end

  // payload follows its pulse
  always_ff @(posedge clk) begin
    if (isIfill) begin
      icFillTag_o <= respTag;
      icFillIndex_o <= respIcIndex;
      icFillData_o <= {triRespData3_i, triRespData2_i, triRespData1_i, triRespData0_i};
    end
    if (isLoad) begin
      dcFillTag_o <= respTag;
      dcFillIndex_o <= respDcIndex;
      dcFillData_o <= {triRespData1_i, triRespData0_i};
    end
    if (isEvict && triRespInvalIc_i) begin
      icInvIndex_o <= respIcIndex;
    end
    if (isEvict && triRespInvalDc_i) begin
      dcInvIndex_o <= respDcIndex;
    end
  end

  // core held in reset until woken
  assign coreReset_o = !wakeFlag;

  aFillExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(icFillValid_o && dcFillValid_o))
    else $error("instruction and data fill pulsed in the same cycle");

endmodule

`default_nettype wire

// File: rtl/triBridge.sv
`timescale 1ns/1ns
`default_nettype none

module triBridge
  import triBridgePkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // instruction cache line fill
  input  logic        icReqValid_i,
  input  icLineAddr_t icReqLineAddr_i,
  output logic        icReqReady_o,
  // data cache line load
  input  logic        dcLdValid_i,
  input  dcLineAddr_t dcLdLineAddr_i,
  output logic        dcLdReady_o,
  // data cache store
  input  logic        dcStValid_i,
  input  paddr_t      dcStAddr_i,
  input  word_t       dcStData_i,
  input  stSize_t     dcStSize_i,
  output logic        dcStReady_o,
  // memory request side
  input  logic        triHeaderAck_i,
  output logic        triReqVal_o,
  output reqType_t    triReqType_o,
  output sizeCode_t   triReqSize_o,
  output paddr_t      triReqAddr_o,
  output word_t       triReqData_o,
  // memory response side
  input  logic        triRespVal_i,
  input  retType_t    triRespType_i,
  input  paddr_t      triRespAddr_i,
  input  word_t       triRespData0_i,
  input  word_t       triRespData1_i,
  input  word_t       triRespData2_i,
  input  word_t       triRespData3_i,
  input  logic        triRespInvalIc_i,
  input  logic        triRespInvalDc_i,
  output logic        triRespAck_o,
  output logic        icFillValid_o,
  output cacheTag_t   icFillTag_o,
  output icIndex_t    icFillIndex_o,
  output icLine_t     icFillData_o,
  output logic        dcFillValid_o,
  output cacheTag_t   dcFillTag_o,
  output dcIndex_t    dcFillIndex_o,
  output dcLine_t     dcFillData_o,
  output logic        stComplete_o,
  output logic        icInvValid_o,
  output icIndex_t    icInvIndex_o,
  output logic        dcInvValid_o,
  output dcIndex_t    dcInvIndex_o,
  output logic        coreReset_o
);

  logic stWin;
  logic ldWin;
  logic icWin;

  cacheReqIf reqBus ();

  // log2 byte count to the request size field
  function automatic sizeCode_t stSizeToCode(input stSize_t sz);
    sizeCode_t code;
    case (sz)
      2'd0: code = SZ_1B;
      2'd1: code = SZ_2B;
      2'd2: code = SZ_4B;
      default: code = SZ_8B;
    endcase
    return code;
  endfunction

  // fixed priority, store then load then ifill
  assign stWin = dcStValid_i;
  assign ldWin = dcLdValid_i && !dcStValid_i;
  assign icWin = icReqValid_i && !dcLdValid_i && !dcStValid_i;

  assign reqBus.valid = stWin || ldWin || icWin;

  // only the winner sees ready, losers keep their valid
  assign dcStReady_o = reqBus.ready && stWin;
  assign dcLdReady_o = reqBus.ready && ldWin;
  assign icReqReady_o = reqBus.ready && icWin;

  // per-kind field formation
  always_comb begin
    if (stWin) begin
      reqBus.kind = KIND_STORE;
      reqBus.addr = dcStAddr_i;
      reqBus.data = dcStData_i;
      reqBus.size = stSizeToCode(dcStSize_i);
    end else if (ldWin) begin
      reqBus.kind = KIND_LOAD;
      reqBus.addr = {dcLdLineAddr_i, {DC_OFFSET_W{1'b0}}};
      reqBus.data = '0;
      reqBus.size = SZ_16B;
    end else begin
      // ifill or idle, valid decides
      reqBus.kind = KIND_IFILL;
      reqBus.addr = {icReqLineAddr_i, {IC_OFFSET_W{1'b0}}};
      reqBus.data = '0;
      reqBus.size = SZ_32B;
    end
  end

  reqArbiter i_reqArbiter (
    .clk            (clk),
    .rst_n          (rst_n),
    .req            (reqBus.sink),
    .triHeaderAck_i (triHeaderAck_i),
    .triReqVal_o    (triReqVal_o),
    .triReqType_o   (triReqType_o),
    .triReqSize_o   (triReqSize_o),
    .triReqAddr_o   (triReqAddr_o),
    .triReqData_o   (triReqData_o)
  );

  respRouter i_respRouter (
    .clk              (clk),
    .rst_n            (rst_n),
    .triRespVal_i     (triRespVal_i),
    .triRespType_i    (triRespType_i),
    .triRespAddr_i    (triRespAddr_i),
    .triRespData0_i   (triRespData0_i),
    .triRespData1_i   (triRespData1_i),
    .triRespData2_i   (triRespData2_i),
    .triRespData3_i   (triRespData3_i),
    .triRespInvalIc_i (triRespInvalIc_i),
    .triRespInvalDc_i (triRespInvalDc_i),
    .triRespAck_o     (triRespAck_o),
    .icFillValid_o    (icFillValid_o),
    .icFillTag_o      (icFillTag_o),
    .icFillIndex_o    (icFillIndex_o),
    .icFillData_o     (icFillData_o),
    .dcFillValid_o    (dcFillValid_o),
    .dcFillTag_o      (dcFillTag_o),
    .dcFillIndex_o    (dcFillIndex_o),
    .dcFillData_o     (dcFillData_o),
    .stComplete_o     (stComplete_o),
    .icInvValid_o     (icInvValid_o),
    .icInvIndex_o     (icInvIndex_o),
    .dcInvValid_o     (dcInvValid_o),
    .dcInvIndex_o     (dcInvIndex_o),
    .coreReset_o      (coreReset_o)
  );

endmodule

`default_nettype wire

// File: rtl/triBridgePkg.sv
`default_nettype none

package triBridgePkg;

  // physical address and data word widths
  localparam int PADDR_W = 40;
  localparam int WORD_W = 64;

  // instruction cache geometry: 32-byte lines, 128 sets
  localparam int IC_OFFSET_W = 5;
  localparam int IC_INDEX_W = 7;
  localparam int IC_WORDS = 4;

  // data cache geometry: 16-byte lines, 256 sets
  localparam int DC_OFFSET_W = 4;
  localparam int DC_INDEX_W = 8;
  localparam int DC_WORDS = 2;

  // both geometries leave the same tag width
  localparam int TAG_W = PADDR_W - IC_OFFSET_W - IC_INDEX_W;

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [PADDR_W-IC_OFFSET_W-1:0] icLineAddr_t;
  typedef logic [PADDR_W-DC_OFFSET_W-1:0] dcLineAddr_t;
  typedef logic [IC_INDEX_W-1:0] icIndex_t;
  typedef logic [DC_INDEX_W-1:0] dcIndex_t;
  typedef logic [TAG_W-1:0] cacheTag_t;
  typedef logic [IC_WORDS*WORD_W-1:0] icLine_t;
  typedef logic [DC_WORDS*WORD_W-1:0] dcLine_t;

  // store size, log2 of the byte count
  typedef logic [1:0] stSize_t;

  typedef logic [4:0] reqType_t;
  typedef logic [3:0] retType_t;
  typedef logic [2:0] sizeCode_t;

  // outgoing request types
  localparam reqType_t RQ_LOAD = 5'd0;
  localparam reqType_t RQ_STORE = 5'd1;
  localparam reqType_t RQ_IMISS = 5'd16;

  // return types seen on the response side
  localparam retType_t RET_LOAD = 4'd0;
  localparam retType_t RET_IFILL = 4'd1;
  localparam retType_t RET_EVICT = 4'd3;
  localparam retType_t RET_STACK = 4'd4;
  localparam retType_t RET_INT = 4'd7;

  // request size field
  localparam sizeCode_t SZ_1B = 3'd0;
  localparam sizeCode_t SZ_2B = 3'd1;
  localparam sizeCode_t SZ_4B = 3'd2;
  localparam sizeCode_t SZ_8B = 3'd3;
  localparam sizeCode_t SZ_16B = 3'd7;
  localparam sizeCode_t SZ_32B = 3'd5;

  typedef enum logic [1:0] {KIND_IFILL, KIND_LOAD, KIND_STORE} reqKind_t;

  typedef enum logic {ARB_IDLE, ARB_WAIT_HDR} arbState_t;

endpackage

`default_nettype wire

// File: sim/triBridgeChecker.sv
`timescale 1ns/1ns
`default_nettype none

module triBridgeChecker
  import triBridgePkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        icReqValid_i, dcLdValid_i, dcStValid_i,
  input logic        icReqReady_o, dcLdReady_o, dcStReady_o,
  input icLineAddr_t icReqLineAddr_i,
  input dcLineAddr_t dcLdLineAddr_i,
  input paddr_t      dcStAddr_i,
  input word_t       dcStData_i,
  input stSize_t     dcStSize_i,
  input logic        triHeaderAck_i, triReqVal_o,
  input reqType_t    triReqType_o,
  input sizeCode_t   triReqSize_o,
  input paddr_t      triReqAddr_o,
  input word_t       triReqData_o,
  input logic        triRespVal_i, triRespInvalIc_i, triRespInvalDc_i, triRespAck_o,
  input retType_t    triRespType_i,
  input paddr_t      triRespAddr_i,
  input word_t       triRespData0_i, triRespData1_i, triRespData2_i, triRespData3_i,
  input logic        icFillValid_o, dcFillValid_o, stComplete_o, coreReset_o,
  input logic        icInvValid_o, dcInvValid_o,
  input cacheTag_t   icFillTag_o, dcFillTag_o,
  input icIndex_t    icFillIndex_o, icInvIndex_o,
  input dcIndex_t    dcFillIndex_o, dcInvIndex_o,
  input icLine_t     icFillData_o,
  input dcLine_t     dcFillData_o
);

  typedef struct packed {
    reqType_t  typ;
    sizeCode_t size;
    paddr_t    addr;
    word_t     data;
  } memReq_t;

  // wide enough for the largest record, the ic fill
  typedef logic [299:0] rec_t;

  string testName = "reset";
  int errCount = 0;
  int checkCount = 0;

  // reference arbiter state and wake flag
  logic refBusy;
  logic refWake;
  memReq_t refReq;

  // responses still owed a pulse on the next clock
  rec_t icFillQ[$];
  rec_t dcFillQ[$];
  rec_t icInvQ[$];
  rec_t dcInvQ[$];
  rec_t stackQ[$];

  // expected memory request for one core request
  function automatic memReq_t expectReq(input reqKind_t kind, input paddr_t addr,
                                        input word_t data, input stSize_t sz);
    memReq_t r;
    r.data = '0;
    case (kind)
      KIND_STORE: begin
        r.typ = RQ_STORE;
        r.size = {1'b0, sz};
        r.addr = addr;
        r.data = data;
      end
      // fills pass the line address in the low bits
      KIND_LOAD: begin
        r.typ = RQ_LOAD;
        r.size = SZ_16B;
        r.addr = addr << 4;
      end
      default: begin
        r.typ = RQ_IMISS;
        r.size = SZ_32B;
        r.addr = addr << 5;
      end
    endcase
    return r;
  endfunction

  task automatic compareValue(input string what, input rec_t expV, input rec_t actV);
    checkCount++;
    if (expV !== actV) begin
      errCount++;
      $display("Fail %s %s: expected %0h, actual %0h", testName, what, expV, actV);
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      refBusy = 1'b0;
      refWake = 1'b0;
      icFillQ.delete();
      dcFillQ.delete();
      icInvQ.delete();
      dcInvQ.delete();
      stackQ.delete();
    end else begin
      // readies follow fixed priority, store then load then ifill
      compareValue("store ready", !refBusy && dcStValid_i, dcStReady_o);
      compareValue("load ready", !refBusy && dcLdValid_i && !dcStValid_i, dcLdReady_o);
      compareValue("ifill ready",
                   !refBusy && icReqValid_i && !dcLdValid_i && !dcStValid_i, icReqReady_o);
      compareValue("req valid", refBusy, triReqVal_o);
      if (refBusy) begin
        // fields must not move until the header ack
        compareValue("req fields", refReq,
                     {triReqType_o, triReqSize_o, triReqAddr_o, triReqData_o});
        if (triHeaderAck_i) begin
          refBusy = 1'b0;
        end
      end else if (dcStValid_i) begin
        refBusy = 1'b1;
        refReq = expectReq(KIND_STORE, dcStAddr_i, dcStData_i, dcStSize_i);
      end else if (dcLdValid_i) begin
        refBusy = 1'b1;
        refReq = expectReq(KIND_LOAD, paddr_t'(dcLdLineAddr_i), '0, '0);
      end else if (icReqValid_i) begin
        refBusy = 1'b1;
        refReq = expectReq(KIND_IFILL, paddr_t'(icReqLineAddr_i), '0, '0);
      end

      // ack is combinational, routed outputs lag one clock
      compareValue("resp ack", triRespVal_i, triRespAck_o);
      compareValue("core reset", !refWake, coreReset_o);
      compareValue("ic fill valid", icFillQ.size() > 0, icFillValid_o);
      if (icFillValid_o && icFillQ.size() > 0) begin
        compareValue("ic fill", icFillQ[0], {icFillTag_o, icFillIndex_o, icFillData_o});
      end
      compareValue("dc fill valid", dcFillQ.size() > 0, dcFillValid_o);
      if (dcFillValid_o && dcFillQ.size() > 0) begin
        compareValue("dc fill", dcFillQ[0], {dcFillTag_o, dcFillIndex_o, dcFillData_o});
      end
      compareValue("ic inv valid", icInvQ.size() > 0, icInvValid_o);
      if (icInvValid_o && icInvQ.size() > 0) begin
        compareValue("ic inv index", icInvQ[0], icInvIndex_o);
      end
      compareValue("dc inv valid", dcInvQ.size() > 0, dcInvValid_o);
      if (dcInvValid_o && dcInvQ.size() > 0) begin
        compareValue("dc inv index", dcInvQ[0], dcInvIndex_o);
      end
      compareValue("store complete", stackQ.size() > 0, stComplete_o);
      icFillQ.delete();
      dcFillQ.delete();
      icInvQ.delete();
      dcInvQ.delete();
      stackQ.delete();

      // tag is addr[39:12], ic index addr[11:5], dc index addr[11:4]
      if (triRespVal_i) begin
        case (triRespType_i)
          RET_IFILL: icFillQ.push_back({triRespAddr_i[39:12], triRespAddr_i[11:5],
              triRespData3_i, triRespData2_i, triRespData1_i, triRespData0_i});
          RET_LOAD: dcFillQ.push_back({triRespAddr_i[39:12], triRespAddr_i[11:4],
              triRespData1_i, triRespData0_i});
          RET_STACK: stackQ.push_back('1);
          RET_EVICT: begin
            if (triRespInvalIc_i) begin
              icInvQ.push_back(triRespAddr_i[11:5]);
            end
            if (triRespInvalDc_i) begin
              dcInvQ.push_back(triRespAddr_i[11:4]);
            end
          end
          RET_INT: refWake = 1'b1;
          // unknown types leave every output quiet
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/triBridgeTb.sv
`timescale 1ns/1ns
`default_nettype none

module triBridgeTb
  import triBridgePkg::*;
();

  localparam int WAIT_LIMIT = 100;

  logic clk;
  logic rst_n;
  logic icReqValid_i, dcLdValid_i, dcStValid_i;
  logic icReqReady_o, dcLdReady_o, dcStReady_o;
  icLineAddr_t icReqLineAddr_i;
  dcLineAddr_t dcLdLineAddr_i;
  paddr_t dcStAddr_i, triReqAddr_o, triRespAddr_i;
  word_t dcStData_i, triReqData_o;
  word_t triRespData0_i, triRespData1_i, triRespData2_i, triRespData3_i;
  stSize_t dcStSize_i;
  logic triHeaderAck_i, triReqVal_o;
  reqType_t triReqType_o;
  sizeCode_t triReqSize_o;
  logic triRespVal_i, triRespInvalIc_i, triRespInvalDc_i, triRespAck_o;
  retType_t triRespType_i;
  logic icFillValid_o, dcFillValid_o, stComplete_o, coreReset_o;
  logic icInvValid_o, dcInvValid_o;
  cacheTag_t icFillTag_o, dcFillTag_o;
  icIndex_t icFillIndex_o, icInvIndex_o;
  dcIndex_t dcFillIndex_o, dcInvIndex_o;
  icLine_t icFillData_o;
  dcLine_t dcFillData_o;

  int ackDelay;
  logic ackPending;
  // 4'd2 is an unused return code
  retType_t respOrder[10] = '{RET_IFILL, RET_LOAD, RET_STACK, RET_EVICT, RET_EVICT,
                              RET_EVICT, 4'd2, RET_IFILL, RET_LOAD, RET_STACK};

  triBridge i_triBridge (.*);
  triBridgeChecker i_checker (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic paddr_t randAddr();
    return paddr_t'({$urandom, $urandom});
  endfunction

  function automatic word_t randWord();
    return {$urandom, $urandom};
  endfunction

  function automatic logic sourceReady(input reqKind_t kind);
    case (kind)
      KIND_STORE: return dcStReady_o;
      KIND_LOAD: return dcLdReady_o;
      default: return icReqReady_o;
    endcase
  endfunction

  task automatic driveSource(input reqKind_t kind, input logic vld, input paddr_t addr,
                             input word_t data, input stSize_t sz);
    case (kind)
      KIND_STORE: begin
        dcStValid_i = vld;
        dcStAddr_i = addr;
        dcStData_i = data;
        dcStSize_i = sz;
      end
      KIND_LOAD: begin
        dcLdValid_i = vld;
        dcLdLineAddr_i = dcLineAddr_t'(addr);
      end
      default: begin
        icReqValid_i = vld;
        icReqLineAddr_i = icLineAddr_t'(addr);
      end
    endcase
  endtask

  // valid held until ready, sampled just after the falling edge
  task automatic issueReq(input reqKind_t kind);
    int n;
    n = 0;
    @(negedge clk);
    driveSource(kind, 1'b1, randAddr(), randWord(), stSize_t'($urandom_range(3, 0)));
    #1;
    while (!sourceReady(kind)) begin
      n++;
      if (n > WAIT_LIMIT) begin
        $display("timeout: %s request was never granted", kind.name());
        $display("CHECKS FAILED");
        $finish;
      end
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    driveSource(kind, 1'b0, randAddr(), randWord(), 2'd0);
  endtask

  task automatic waitIdle();
    int n;
    n = 0;
    @(negedge clk);
    while (triReqVal_o) begin
      n++;
      if (n > WAIT_LIMIT) begin
        $display("timeout: memory request never left the bridge");
        $display("CHECKS FAILED");
        $finish;
      end
      @(negedge clk);
    end
  endtask

  // one response beat, flags random for every type
  task automatic sendResp(input retType_t typ);
    @(negedge clk);
    triRespVal_i = 1'b1;
    triRespType_i = typ;
    triRespAddr_i = randAddr();
    triRespData0_i = randWord();
    triRespData1_i = randWord();
    triRespData2_i = randWord();
    triRespData3_i = randWord();
    triRespInvalIc_i = $urandom_range(1, 0);
    triRespInvalDc_i = $urandom_range(1, 0);
  endtask

  // memory side, header ack 0 to 5 cycles after valid
  initial begin
    triHeaderAck_i = 1'b0;
    ackPending = 1'b0;
    ackDelay = 0;
    forever begin
      @(negedge clk);
      triHeaderAck_i = 1'b0;
      if (triReqVal_o) begin
        if (!ackPending) begin
          ackDelay = $urandom_range(5, 0);
          ackPending = 1'b1;
        end
        if (ackDelay == 0) begin
          triHeaderAck_i = 1'b1;
          ackPending = 1'b0;
        end else begin
          ackDelay--;
        end
      end
    end
  end

  initial begin
    int j;
    retType_t swapType;
    void'($urandom(96816));
    icReqValid_i = 1'b0;
    icReqLineAddr_i = '0;
    dcLdValid_i = 1'b0;
    dcLdLineAddr_i = '0;
    dcStValid_i = 1'b0;
    dcStAddr_i = '0;
    dcStData_i = '0;
    dcStSize_i = '0;
    triRespVal_i = 1'b0;
    triRespType_i = '0;
    triRespAddr_i = '0;
    triRespData0_i = '0;
    triRespData1_i = '0;
    triRespData2_i = '0;
    triRespData3_i = '0;
    triRespInvalIc_i = 1'b0;
    triRespInvalDc_i = 1'b0;
    rst_n = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    i_checker.testName = "single requests";
    repeat (4) begin
      issueReq(KIND_IFILL);
      issueReq(KIND_LOAD);
      issueReq(KIND_STORE);
    end
    waitIdle();

    // all three sources pending together
    i_checker.testName = "priority";
    repeat (4) begin
      fork
        issueReq(KIND_IFILL);
        issueReq(KIND_LOAD);
        issueReq(KIND_STORE);
      join
    end
    waitIdle();

    // shuffled responses while the core still sits in reset
    i_checker.testName = "responses";
    for (int i = 9; i > 0; i--) begin
      j = $urandom_range(i, 0);
      swapType = respOrder[i];
      respOrder[i] = respOrder[j];
      respOrder[j] = swapType;
    end
    foreach (respOrder[k]) begin
      sendResp(respOrder[k]);
    end

    // release, then more traffic after it
    i_checker.testName = "wake";
    sendResp(RET_INT);
    sendResp(RET_LOAD);
    sendResp(RET_IFILL);
    sendResp(RET_STACK);
    @(negedge clk);
    triRespVal_i = 1'b0;
    repeat (3) @(negedge clk);

    $display("%0d checks, %0d errors", i_checker.checkCount, i_checker.errCount);
    if (i_checker.errCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: triBridge.f
rtl/triBridgePkg.sv
rtl/cacheReqIf.sv
rtl/reqArbiter.sv
rtl/respRouter.sv
rtl/triBridge.sv
sim/triBridgeChecker.sv
sim/triBridgeTb.sv
